//--- Bender.yml
package:
  name: dc_fifo

sources:
  # Design, package first
  - files:
      - verilog/dc_fifo_pkg.sv
      - verilog/ptr_cdc.sv
      - verilog/ram_tp.sv
      - verilog/dc_fifo.sv

  # Testbench and bound assertions
  - target: test
    files:
      - verif/dc_fifo_properties.sv
      - verif/dc_fifo_tb.sv

//--- dc_fifo.f
verilog/dc_fifo_pkg.sv
verilog/ptr_cdc.sv
verilog/ram_tp.sv
verilog/dc_fifo.sv
verif/dc_fifo_properties.sv
verif/dc_fifo_tb.sv

//--- verif/dc_fifo_cases.txt
# name mode write_word expected_low expected_high
# mode is stream, fill, guard, count or random; words in hex
s_0 stream 0123456789abcdef 89abcdef 01234567
s_1 stream fedcba9876543210 76543210 fedcba98
s_2 stream 00000000ffffffff ffffffff 00000000
s_3 stream ffffffff00000000 00000000 ffffffff
s_4 stream a5a5a5a55a5a5a5a 5a5a5a5a a5a5a5a5
s_5 stream 1122334455667788 55667788 11223344
fill_0 fill c0de0000f00d0000 f00d0000 c0de0000
g_0 guard 0badc0de00000001 00000001 0badc0de
g_1 guard 0badc0de00000002 00000002 0badc0de
g_2 guard 13579bdf2468ace0 2468ace0 13579bdf
c_0 count 1000000000000001 00000001 10000000
c_1 count 2000000000000002 00000002 20000000
c_2 count 3000000000000003 00000003 30000000
c_3 count 4000000000000004 00000004 40000000
c_4 count 5000000000000005 00000005 50000000
r_00 random 8badf00ddeadbeef deadbeef 8badf00d
r_01 random 0f0f0f0ff0f0f0f0 f0f0f0f0 0f0f0f0f
r_02 random 7fffffff80000000 80000000 7fffffff
r_03 random 0000000100000002 00000002 00000001
r_04 random 3c3c3c3cc3c3c3c3 c3c3c3c3 3c3c3c3c
r_05 random 6b8b4567327b23c6 327b23c6 6b8b4567
r_06 random 643c986966334873 66334873 643c9869
r_07 random 74b0dc5119495cff 19495cff 74b0dc51
r_08 random 2ae8944a625558ec 625558ec 2ae8944a
r_09 random 238e1f2946e87ccd 46e87ccd 238e1f29
r_10 random 3d1b58ba507ed7ab 507ed7ab 3d1b58ba
r_11 random 2eb141f241b71efb 41b71efb 2eb141f2

//--- verif/dc_fifo_properties.sv
`timescale 1ns/1ps

module dc_fifo_properties (
    input logic                    wr_clk_i,
    input logic                    wr_rst_n_i,
    input dc_fifo_pkg::wr_status_t wr_status_o,
    input logic                    rd_clk_i,
    input logic                    rd_rst_n_i,
    input logic                    rd_en_i,
    input dc_fifo_pkg::rd_status_t rd_status_o
);
    import dc_fifo_pkg::*;

    a_full_known: assert property (@(posedge wr_clk_i) disable iff (!wr_rst_n_i)
        !$isunknown(wr_status_o.full))
        else $error("full is unknown on the write side");

    a_empty_known: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        !$isunknown(rd_status_o.empty))
        else $error("empty is unknown on the read side");

    a_free_max: assert property (@(posedge wr_clk_i) disable iff (!wr_rst_n_i)
        wr_status_o.free <= WR_DEPTH)
        else $error("free count above the write depth");

    a_avail_max: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        rd_status_o.avail <= RD_DEPTH)
        else $error("avail count above the read depth");

    // An idle reader sits on a word boundary
    a_avail_even: assert property (@(posedge rd_clk_i) disable iff (!rd_rst_n_i)
        (!rd_en_i && !$past(rd_en_i, 1) && !$past(rd_en_i, 2) && !$past(rd_en_i, 3))
        |-> !rd_status_o.avail[0])
        else $error("avail is odd while the read side is idle");

endmodule

bind dc_fifo dc_fifo_properties u_props (.*);

//--- verif/dc_fifo_tb.sv
`timescale 1ns/1ps

module dc_fifo_tb;
    import dc_fifo_pkg::*;

    localparam int          RD_PERIOD = 4;
    localparam int          WR_PERIOD = 6;
    localparam int          QUIET     = 8;   // Cycles for the pointers to settle
    localparam logic [31:0] LFSR_SEED = 32'h622d_28d5;

    logic       wr_clk_i;
    logic       wr_rst_n_i;
    logic       wr_en_i;
    wr_word_t   wr_data_i;
    wr_status_t wr_status_o;
    logic       rd_clk_i;
    logic       rd_rst_n_i;
    logic       rd_en_i;
    rd_word_t   rd_data_o;
    rd_status_t rd_status_o;

    // Cases as loaded from the file
    string    case_name [$];
    string    case_mode [$];
    wr_word_t case_word [$];
    rd_word_t case_lo   [$];
    rd_word_t case_hi   [$];

    // Reference model, read words still owed by the DUT
    rd_word_t    exp_q    [$];
    string       exp_name [$];
    rd_word_t    last_exp;      // Last word handed out by the read side
    logic [31:0] lfsr_q;

    dc_fifo u_dut (
        .wr_clk_i   (wr_clk_i),
        .wr_rst_n_i (wr_rst_n_i),
        .wr_en_i    (wr_en_i),
        .wr_data_i  (wr_data_i),
        .wr_status_o(wr_status_o),
        .rd_clk_i   (rd_clk_i),
        .rd_rst_n_i (rd_rst_n_i),
        .rd_en_i    (rd_en_i),
        .rd_data_o  (rd_data_o),
        .rd_status_o(rd_status_o)
    );

    initial begin
        rd_clk_i = 1'b0;
        forever #(RD_PERIOD / 2) rd_clk_i = ~rd_clk_i;
    end

    initial begin
        wr_clk_i = 1'b0;
        forever #(WR_PERIOD / 2) wr_clk_i = ~wr_clk_i;
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Stopped at first failure");
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic take_bit();
        lfsr_q = lfsr_next(lfsr_q);
        return lfsr_q[31];
    endfunction

    function automatic int rand_count(input int nbits);
        int n;
        n = 0;
        for (int i = 0; i < nbits; i++) begin
            n = (n << 1) | int'(take_bit());
        end
        return n;
    endfunction

    function automatic wr_status_t wr_expect(input int held);
        wr_status_t s;
        s.full = (held == WR_DEPTH);
        s.free = (WR_ADDR_W + 1)'(WR_DEPTH - held);
        return s;
    endfunction

    function automatic rd_status_t rd_expect(input int halves);
        rd_status_t s;
        s.empty = (halves == 0);
        s.avail = (RD_ADDR_W + 1)'(halves);
        return s;
    endfunction

    task automatic check_word(input string name, input rd_word_t exp, input rd_word_t act);
        if (act !== exp) begin
            $display("ERROR %s: rd_data_o expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_wr_status(input string name, input wr_status_t exp,
                                   input wr_status_t act);
        if (act !== exp) begin
            $display("ERROR %s: wr_status_o expected full %b free %0d, actual full %b free %0d",
                     name, exp.full, exp.free, act.full, act.free);
            abort_run();
        end
    endtask

    task automatic check_rd_status(input string name, input rd_status_t exp,
                                   input rd_status_t act);
        if (act !== exp) begin
            $display("ERROR %s: rd_status_o expected empty %b avail %0d, actual empty %b avail %0d",
                     name, exp.empty, exp.avail, act.empty, act.avail);
            abort_run();
        end
    endtask

    function automatic bit known_mode(input string m);
        return m == "stream" || m == "fill" || m == "guard" || m == "count" || m == "random";
    endfunction

    task automatic load_cases();
        int       fd;
        int       r;
        string    tok;
        string    mode;
        string    rest;
        wr_word_t w;
        rd_word_t lo;
        rd_word_t hi;
        fd = $fopen("verif/dc_fifo_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verif/dc_fifo_cases.txt");
            abort_run();
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[0] == "#") begin
                r = $fgets(rest, fd);  // Skip the rest of a comment line
            end else begin
                r = $fscanf(fd, "%s %h %h %h", mode, w, lo, hi);
                if (r != 4 || !known_mode(mode)) begin
                    $display("Malformed line for case %s in the cases file", tok);
                    abort_run();
                end
                case_name.push_back(tok);
                case_mode.push_back(mode);
                case_word.push_back(w);
                case_lo.push_back(lo);
                case_hi.push_back(hi);
            end
        end
        $fclose(fd);
        if (case_name.size() == 0) begin
            $display("The cases file holds no cases");
            abort_run();
        end
    endtask

    task automatic watchdog();
        longint limit;
        limit = longint'(case_name.size() * 200 + 1000) * RD_PERIOD;
        #(limit);
        $display("Timeout, the run did not finish within %0d ns", limit);
        abort_run();
    endtask

    // Waits for room, then one accepted write
    task automatic write_word(input string name, input wr_word_t word,
                              input rd_word_t lo, input rd_word_t hi);
        @(negedge wr_clk_i);
        while (wr_status_o.full) begin
            @(negedge wr_clk_i);
        end
        @(posedge wr_clk_i);
        wr_en_i   <= 1'b1;
        wr_data_i <= word;
        @(posedge wr_clk_i);   // Accepted here
        wr_en_i <= 1'b0;
        exp_q.push_back(lo);   // Low half comes out first
        exp_q.push_back(hi);
        exp_name.push_back(name);
        exp_name.push_back(name);
    endtask

    // One write pulse that ignores full
    task automatic force_write(input wr_word_t word);
        @(posedge wr_clk_i);
        wr_en_i   <= 1'b1;
        wr_data_i <= word;
        @(posedge wr_clk_i);
        wr_en_i <= 1'b0;
    endtask

    task automatic read_half(output rd_word_t data);
        @(negedge rd_clk_i);
        while (rd_status_o.empty) begin
            @(negedge rd_clk_i);
        end
        @(posedge rd_clk_i);
        rd_en_i <= 1'b1;
        @(posedge rd_clk_i);   // Accepted here, output register loads
        rd_en_i <= 1'b0;
        @(negedge rd_clk_i);
        data = rd_data_o;
    endtask

    // Both halves back to back, so the read side rests on word boundaries
    task automatic pop_word();
        rd_word_t act;
        for (int h = 0; h < 2; h++) begin
            read_half(act);
            if (exp_q.size() == 0) begin
                $display("Read side delivered a word although none was pending");
                abort_run();
            end
            check_word(exp_name[0], exp_q[0], act);
            last_exp = exp_q.pop_front();
            exp_name.delete(0);
        end
    endtask

    task automatic drain();
        while (exp_q.size() > 0) begin
            pop_word();
        end
    endtask

    task automatic settle();
        repeat (QUIET) @(posedge wr_clk_i);
        repeat (QUIET) @(posedge rd_clk_i);
    endtask

    // A partly read word still counts as held on the write side
    task automatic check_counts(input string name);
        int halves;
        int held;
        halves = exp_q.size();
        held   = (halves + 1) / 2;
        @(negedge wr_clk_i);
        check_wr_status(name, wr_expect(held), wr_status_o);
        @(negedge rd_clk_i);
        check_rd_status(name, rd_expect(halves), rd_status_o);
    endtask

    task automatic run_stream();
        foreach (case_name[c]) begin
            if (case_mode[c] == "stream") begin
                write_word(case_name[c], case_word[c], case_lo[c], case_hi[c]);
            end
        end
        drain();
        settle();
        check_counts("stream_end");
    endtask

    task automatic run_fill();
        int accepted;
        foreach (case_name[c]) begin
            if (case_mode[c] == "fill") begin
                for (int i = 0; i <= WR_DEPTH; i++) begin
                    force_write(case_word[c] ^ {rd_word_t'(i), rd_word_t'(i)});
                    if (i < WR_DEPTH) begin  // The extra word is dropped
                        exp_q.push_back(case_lo[c] ^ rd_word_t'(i));
                        exp_q.push_back(case_hi[c] ^ rd_word_t'(i));
                        exp_name.push_back(case_name[c]);
                        exp_name.push_back(case_name[c]);
                    end
                    accepted = (i < WR_DEPTH) ? i + 1 : WR_DEPTH;
                    @(negedge wr_clk_i);
                    check_wr_status(case_name[c], wr_expect(accepted), wr_status_o);
                end
                settle();
                check_counts(case_name[c]);
                drain();
                settle();
                check_counts(case_name[c]);
            end
        end
    endtask

    task automatic run_guard();
        foreach (case_name[c]) begin
            if (case_mode[c] == "guard") begin
                @(posedge rd_clk_i);
                rd_en_i <= 1'b1;               // Reads against an empty FIFO
                repeat (3) @(posedge rd_clk_i);
                rd_en_i <= 1'b0;
                @(negedge rd_clk_i);
                check_word(case_name[c], last_exp, rd_data_o);
                check_counts(case_name[c]);
                write_word(case_name[c], case_word[c], case_lo[c], case_hi[c]);
                pop_word();
                settle();
            end
        end
    endtask

    task automatic run_count();
        foreach (case_name[c]) begin
            if (case_mode[c] == "count") begin
                write_word(case_name[c], case_word[c], case_lo[c], case_hi[c]);
                settle();
                check_counts(case_name[c]);
            end
        end
        while (exp_q.size() > 0) begin
            pop_word();
            settle();
            check_counts("count_read");
        end
    endtask

    task automatic run_random();
        int idx      [$];
        int wr_stall [$];
        int rd_stall [$];
        foreach (case_name[c]) begin
            if (case_mode[c] == "random") begin
                idx.push_back(c);
            end
        end
        // Stalls drawn up front so the sequence is the same on every simulator
        foreach (idx[k]) begin
            wr_stall.push_back(rand_count(2));
            rd_stall.push_back(rand_count(3));  // Reader a bit slower
        end
        fork
            begin
                foreach (idx[k]) begin
                    repeat (wr_stall[k]) @(posedge wr_clk_i);
                    write_word(case_name[idx[k]], case_word[idx[k]],
                               case_lo[idx[k]], case_hi[idx[k]]);
                end
            end
            begin
                foreach (rd_stall[k]) begin
                    repeat (rd_stall[k]) @(posedge rd_clk_i);
                    pop_word();
                end
            end
        join
        settle();
        check_counts("random_end");
    endtask

    initial begin
        wr_rst_n_i = 1'b0;
        rd_rst_n_i = 1'b0;
        wr_en_i    = 1'b0;
        rd_en_i    = 1'b0;
        wr_data_i  = '0;
        lfsr_q     = LFSR_SEED;
        last_exp   = '0;     // Output register resets to zero
        load_cases();
        fork
            watchdog();
        join_none
        repeat (10) @(posedge rd_clk_i);
        wr_rst_n_i <= 1'b1;
        rd_rst_n_i <= 1'b1;
        @(negedge rd_clk_i);
        check_word("reset", '0, rd_data_o);
        check_counts("reset");
        run_stream();
        run_fill();
        run_guard();
        run_count();
        run_random();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verilog/dc_fifo.sv
`timescale 1ns/1ps

module dc_fifo (
    // Write domain
    input  logic                    wr_clk_i,
    input  logic                    wr_rst_n_i,
    input  logic                    wr_en_i,
    input  dc_fifo_pkg::wr_word_t   wr_data_i,
    output dc_fifo_pkg::wr_status_t wr_status_o,

    // Read domain
    input  logic                    rd_clk_i,
    input  logic                    rd_rst_n_i,
    input  logic                    rd_en_i,
    output dc_fifo_pkg::rd_word_t   rd_data_o,
    output dc_fifo_pkg::rd_status_t rd_status_o
);
    import dc_fifo_pkg::*;

    // Write domain state
    wr_ptr_t wr_ptr_q;      // Write pointer, binary
    rd_ptr_t rd_ptr_wr;     // Read pointer as seen by the write side
    wr_ptr_t rd_ptr_wr_ext; // Same, in write words
    wr_ptr_t wr_used;       // Write words held or partly read
    wr_ptr_t wr_free;
    logic    wr_full;
    logic    wr_push;       // Accepted write

    // Read domain state
    rd_ptr_t rd_ptr_q;      // Read pointer, binary
    wr_ptr_t wr_ptr_rd;     // Write pointer as seen by the read side
    rd_ptr_t wr_ptr_rd_ext; // Same, in read words
    rd_ptr_t rd_avail;
    logic    rd_empty;
    logic    rd_pop;        // Accepted read

    // Write side

    assign wr_push = wr_en_i & ~wr_full;  // Writes while full are dropped

    always_ff @(posedge wr_clk_i or negedge wr_rst_n_i) begin
        if (!wr_rst_n_i) begin
            wr_ptr_q <= '0;
        end else if (wr_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    // A partly read entry still counts as occupied
    assign rd_ptr_wr_ext = rd_ptr_wr[RD_ADDR_W:RATIO_LOG];

    // Same address, opposite lap
    assign wr_full = (wr_ptr_q == {~rd_ptr_wr_ext[WR_ADDR_W], rd_ptr_wr_ext[WR_ADDR_W-1:0]});

    assign wr_used = wr_ptr_q - rd_ptr_wr_ext;
    assign wr_free = wr_ptr_t'(WR_DEPTH) - wr_used;

    assign wr_status_o.full = wr_full;
    assign wr_status_o.free = wr_free;

    // Read side

    assign rd_pop = rd_en_i & ~rd_empty;  // Reads while empty are ignored

    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            rd_ptr_q <= '0;
        end else if (rd_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    // Each write word counts as 2**RATIO_LOG read words
    assign wr_ptr_rd_ext = {wr_ptr_rd, {RATIO_LOG{1'b0}}};

    assign rd_empty = (rd_ptr_q == wr_ptr_rd_ext);
    assign rd_avail = wr_ptr_rd_ext - rd_ptr_q;

    assign rd_status_o.empty = rd_empty;
    assign rd_status_o.avail = rd_avail;

    // Pointer crossings

    ptr_cdc #(
        .ptr_t(wr_ptr_t)
    ) u_wr2rd (
        .src_clk_i  (wr_clk_i),
        .src_rst_n_i(wr_rst_n_i),
        .src_ptr_i  (wr_ptr_q),
        .dst_clk_i  (rd_clk_i),
        .dst_rst_n_i(rd_rst_n_i),
        .dst_ptr_o  (wr_ptr_rd)
    );

    ptr_cdc #(
        .ptr_t(rd_ptr_t)
    ) u_rd2wr (
        .src_clk_i  (rd_clk_i),
        .src_rst_n_i(rd_rst_n_i),
        .src_ptr_i  (rd_ptr_q),
        .dst_clk_i  (wr_clk_i),
        .dst_rst_n_i(wr_rst_n_i),
        .dst_ptr_o  (rd_ptr_wr)
    );

    // Storage, the wrap bits stay out of the addresses
    ram_tp u_ram (
        .wr_clk_i  (wr_clk_i),
        .wr_en_i   (wr_push),
        .wr_addr_i (wr_ptr_q[WR_ADDR_W-1:0]),
        .wr_data_i (wr_data_i),
        .rd_clk_i  (rd_clk_i),
        .rd_rst_n_i(rd_rst_n_i),
        .rd_en_i   (rd_pop),
        .rd_addr_i (rd_ptr_q[RD_ADDR_W-1:0]),
        .rd_data_o (rd_data_o)
    );

endmodule

//--- verilog/dc_fifo_pkg.sv
package dc_fifo_pkg;

    // Write side geometry
    localparam int WR_WIDTH = 64;
    localparam int WR_DEPTH = 32;

    // Read side geometry, same storage seen as half words
    localparam int RD_WIDTH = 32;
    localparam int RD_DEPTH = 64;

    // log2 of read words per write word
    localparam int RATIO_LOG = 1;

    // Flops per pointer crossing
    localparam int SYNC_STAGES = 2;

    // Address widths without the wrap bit
    localparam int WR_ADDR_W = $clog2(WR_DEPTH);  // 5
    localparam int RD_ADDR_W = $clog2(RD_DEPTH);  // 6

    // Data words
    typedef logic [WR_WIDTH-1:0] wr_word_t;
    typedef logic [RD_WIDTH-1:0] rd_word_t;

    // Binary pointers, MSB is the wrap bit
    typedef logic [WR_ADDR_W:0] wr_ptr_t;  // Counts write words
    typedef logic [RD_ADDR_W:0] rd_ptr_t;  // Counts read words

    // Write side status, free is in write words
    typedef struct packed {
        logic               full;
        logic [WR_ADDR_W:0] free;
    } wr_status_t;

    // Read side status, avail is in read words
    typedef struct packed {
        logic               empty;
        logic [RD_ADDR_W:0] avail;
    } rd_status_t;

endpackage

//--- verilog/ptr_cdc.sv
`timescale 1ns/1ps

module ptr_cdc #(
    parameter type ptr_t = dc_fifo_pkg::wr_ptr_t
) (
    // Source domain
    input  logic src_clk_i,
    input  logic src_rst_n_i,
    input  ptr_t src_ptr_i,    // Binary pointer

    // Destination domain
    input  logic dst_clk_i,
    input  logic dst_rst_n_i,
    output ptr_t dst_ptr_o     // Binary pointer, delayed
);
    import dc_fifo_pkg::*;

    localparam int PTR_W = $bits(ptr_t);

    ptr_t gray_q;                 // Gray code launched from the source domain
    ptr_t sync_q [SYNC_STAGES];   // Synchronizer chain

    // Adjacent pointer values differ in one bit once Gray coded
    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Each binary bit is the XOR of all Gray bits at and above it
    function automatic ptr_t gray2bin(input ptr_t gray);
        ptr_t bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // Registered so no combinational glitch reaches the other clock
    always_ff @(posedge src_clk_i or negedge src_rst_n_i) begin
        if (!src_rst_n_i) begin
            gray_q <= '0;
        end else begin
            gray_q <= bin2gray(src_ptr_i);
        end
    end

    // First stage may go metastable, later stages settle it
    always_ff @(posedge dst_clk_i or negedge dst_rst_n_i) begin
        if (!dst_rst_n_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
        end else begin
            sync_q[0] <= gray_q;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // Back to binary for the pointer arithmetic on this side
    assign dst_ptr_o = gray2bin(sync_q[SYNC_STAGES-1]);

endmodule

//--- verilog/ram_tp.sv
`timescale 1ns/1ps

module ram_tp (
    // Write port, full words
    input  logic                              wr_clk_i,
    input  logic                              wr_en_i,
    input  logic [dc_fifo_pkg::WR_ADDR_W-1:0] wr_addr_i,
    input  dc_fifo_pkg::wr_word_t             wr_data_i,

    // Read port, one part of a word per access
    input  logic                              rd_clk_i,
    input  logic                              rd_rst_n_i,
    input  logic                              rd_en_i,
    input  logic [dc_fifo_pkg::RD_ADDR_W-1:0] rd_addr_i,
    output dc_fifo_pkg::rd_word_t             rd_data_o
);
    import dc_fifo_pkg::*;

    // Read words per stored entry
    localparam int PARTS = 1 << RATIO_LOG;

    wr_word_t             mem_q [WR_DEPTH];  // Storage array
    logic [WR_ADDR_W-1:0] rd_entry;          // Entry holding the addressed part
    logic [RATIO_LOG-1:0] rd_part;           // Part within the entry
    rd_word_t [PARTS-1:0] rd_parts;          // Entry split into read words
    rd_word_t             rd_data_q;         // Output register

    // Write side
    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // Upper address bits pick the entry, low bits the part
    assign rd_entry = rd_addr_i[RD_ADDR_W-1:RATIO_LOG];
    assign rd_part  = rd_addr_i[RATIO_LOG-1:0];

    // Part 0 lands on the least significant bits, so low half reads first
    assign rd_parts = mem_q[rd_entry];

    // Output only moves on an accepted read and holds otherwise
    always_ff @(posedge rd_clk_i or negedge rd_rst_n_i) begin
        if (!rd_rst_n_i) begin
            rd_data_q <= '0;
        end else if (rd_en_i) begin
            rd_data_q <= rd_parts[rd_part];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule
